// File: common/icache_pkg.sv
/* icache geometry localparams, address, data and way types,
   controller state enum and address field helpers */

package icache_pkg;

  ////////////////////////////////////////////////////////////
  // geometry
  ////////////////////////////////////////////////////////////

  // fetch port and line widths
  localparam int ADDR_WIDTH   = 32;
  localparam int WORD_WIDTH   = 32;
  localparam int LINE_WIDTH   = 128;

  // 4 ways of 64 sets with 16 byte lines
  localparam int NUM_WAYS     = 4;
  localparam int NUM_SETS     = 64;
  localparam int OFFSET_WIDTH = 4;
  localparam int INDEX_WIDTH  = 6;
  localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

  // upper half of the address space bypasses the cache
  localparam int NC_BIT       = 31;

  // random replacement source
  localparam int LFSR_WIDTH   = 8;

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  typedef logic [ADDR_WIDTH-1:0]        addr_t;
  typedef logic [WORD_WIDTH-1:0]        word_t;
  typedef logic [LINE_WIDTH-1:0]        line_t;
  typedef logic [TAG_WIDTH-1:0]         tag_t;
  typedef logic [INDEX_WIDTH-1:0]       index_t;
  typedef logic [$clog2(NUM_WAYS)-1:0]  way_idx_t;
  typedef logic [NUM_WAYS-1:0]          way_oh_t;

  // controller states
  typedef enum logic [2:0] {
    FLUSH,
    IDLE,
    READ,
    MISS
  } ctrl_state_e;

  ////////////////////////////////////////////////////////////
  // address fields
  ////////////////////////////////////////////////////////////

  // tag sits above index and offset
  function automatic tag_t addr_tag(input addr_t addr);
    return addr[ADDR_WIDTH-1 -: TAG_WIDTH];
  endfunction

  function automatic index_t addr_index(input addr_t addr);
    return addr[OFFSET_WIDTH +: INDEX_WIDTH];
  endfunction

  // word within the line, byte bits dropped
  function automatic logic [OFFSET_WIDTH-$clog2(WORD_WIDTH/8)-1:0] addr_word(input addr_t addr);
    return addr[OFFSET_WIDTH-1:$clog2(WORD_WIDTH/8)];
  endfunction

endpackage

// File: verilog/sram_1rw.sv
/* single-port synchronous RAM, one cycle read latency */

`timescale 1ns/1ps

module sram_1rw #(
  parameter int DATA_WIDTH = 32,
  parameter int NUM_WORDS  = 64
) (
  input  logic                         clk_i,
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [$clog2(NUM_WORDS)-1:0] addr_i,
  input  logic [DATA_WIDTH-1:0]        wdata_i,
  output logic [DATA_WIDTH-1:0]        rdata_o
);

  logic [DATA_WIDTH-1:0] mem [NUM_WORDS];

  // read data holds when the RAM is idle or written
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

// File: icache/icache_ctrl.sv
/* icache controller FSM, request address register, enable and
   pending flush tracking, flush counter */

`timescale 1ns/1ps

module icache_ctrl (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               en_i,
  input  logic               flush_i,
  // fetch side
  input  logic               req_i,
  input  icache_pkg::addr_t  addr_i,
  output logic               ready_o,
  output logic               valid_o,
  output logic               miss_o,
  // lookup result and data source
  input  logic               hit_i,
  output logic               from_mem_o,
  // memory side
  output logic               mem_req_o,
  output icache_pkg::addr_t  mem_addr_o,
  output logic               mem_nc_o,
  input  logic               mem_ack_i,
  input  logic               mem_rtrn_vld_i,
  // array control
  output logic               rd_en_o,
  output logic               wr_en_o,
  output logic               lookup_o,
  output logic               flush_en_o,
  output icache_pkg::index_t flush_idx_o,
  output icache_pkg::addr_t  addr_d_o,
  output icache_pkg::addr_t  addr_q_o
);

  import icache_pkg::*;

  ctrl_state_e state_d, state_q;
  logic        cache_en_d, cache_en_q;
  logic        flush_d, flush_q;
  logic        lookup_d, lookup_q;
  index_t      flush_cnt_d, flush_cnt_q;
  addr_t       addr_q;
  logic        is_nc;

  ////////////////////////////////////////////////////////////
  // address and memory request fields
  ////////////////////////////////////////////////////////////

  // new address only when a request is accepted
  assign addr_d_o = rd_en_o ? addr_i : addr_q;
  assign addr_q_o = addr_q;

  // upper half of the address space or a disabled cache
  assign is_nc    = addr_q[NC_BIT] | ~cache_en_q;
  assign mem_nc_o = is_nc;

  // word aligned for NC, line aligned for refills
  assign mem_addr_o = is_nc ? {addr_q[ADDR_WIDTH-1:2], 2'b00} :
                              {addr_q[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};

  // RAM read goes with every accepted request
  assign rd_en_o    = ready_o & req_i;
  // tag compare only when the cache is on
  assign lookup_d   = rd_en_o & cache_en_q;
  assign lookup_o   = lookup_q;

  // responses from MISS come straight off the return bus
  assign from_mem_o = (state_q == MISS);

  // one set cleared per cycle, wraps to zero when done
  assign flush_idx_o = flush_cnt_q;
  assign flush_cnt_d = flush_en_o ? flush_cnt_q + 1'b1 : flush_cnt_q;

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    // disabling is immediate, enabling only via a flush
    cache_en_d = cache_en_q & en_i;
    flush_d    = flush_q | flush_i;
    ready_o    = 1'b0;
    valid_o    = 1'b0;
    miss_o     = 1'b0;
    mem_req_o  = 1'b0;
    wr_en_o    = 1'b0;
    flush_en_o = 1'b0;

    unique case (state_q)
      // clear all valid bits
      FLUSH: begin
        flush_en_o = 1'b1;
        if (flush_cnt_q == index_t'(NUM_SETS - 1)) begin
          state_d    = IDLE;
          flush_d    = 1'b0;
          cache_en_d = en_i;
        end
      end
      // wait for a fetch
      IDLE: begin
        // pending flush or a fresh enable clears the arrays
        if (flush_d || (en_i && !cache_en_q)) begin
          state_d = FLUSH;
        end else begin
          ready_o = 1'b1;
          if (req_i) begin
            state_d = READ;
          end
        end
      end
      // tag compare on the RAM outputs
      // NC and disabled fetches take the miss path
      READ: begin
        if (hit_i) begin
          valid_o = 1'b1;
          state_d = IDLE;
          // back-to-back hit unless a flush is waiting
          if (!flush_d) begin
            ready_o = 1'b1;
            if (req_i) begin
              state_d = READ;
            end
          end
        end else begin
          // held until memory takes it
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = ~is_nc;
            state_d = MISS;
          end
        end
      end
      // refill or NC word comes back, always taken
      MISS: begin
        if (mem_rtrn_vld_i) begin
          valid_o = 1'b1;
          // NC data never lands in the arrays
          wr_en_o = ~is_nc;
          state_d = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FLUSH;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
      lookup_q    <= 1'b0;
      flush_cnt_q <= '0;
    end else begin
      state_q     <= state_d;
      cache_en_q  <= cache_en_d;
      flush_q     <= flush_d;
      lookup_q    <= lookup_d;
      flush_cnt_q <= flush_cnt_d;
    end
  end

  // fetch address of the request in flight
  always_ff @(posedge clk_i) begin
    addr_q <= addr_d_o;
  end

  // FSM never leaves its four states
  a_state_legal: assert property (
    @(posedge clk_i) disable iff (!rst_ni) state_q inside {FLUSH, IDLE, READ, MISS})
    else $error("icache ctrl reached an illegal state");

  // memory only acknowledges a pending request
  a_ack_with_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni) mem_ack_i |-> mem_req_o)
    else $error("mem_ack_i without mem_req_o");

endmodule

// File: icache/icache_arrays.sv
/* per-way tag plus valid RAMs and data RAMs with address
   and way enable muxing */

`timescale 1ns/1ps

module icache_arrays (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic                                            rd_en_i,
  input  logic                                            wr_en_i,
  input  logic                                            flush_en_i,
  input  icache_pkg::index_t                              flush_idx_i,
  input  icache_pkg::addr_t                               addr_d_i,
  input  icache_pkg::addr_t                               addr_q_i,
  input  icache_pkg::way_oh_t                             repl_oh_i,
  input  icache_pkg::line_t                               line_i,
  output icache_pkg::tag_t  [icache_pkg::NUM_WAYS-1:0]    tags_o,
  output icache_pkg::way_oh_t                             valid_o,
  output icache_pkg::line_t [icache_pkg::NUM_WAYS-1:0]    lines_o
);

  import icache_pkg::*;

  index_t  ram_idx;
  way_oh_t tag_req;
  way_oh_t data_req;
  logic    tag_we;

  // flush index, then new address on reads, held address on refills
  assign ram_idx = flush_en_i ? flush_idx_i          :
                   rd_en_i    ? addr_index(addr_d_i) :
                                addr_index(addr_q_i);

  // all ways read or cleared, only the victim way written
  assign tag_req  = (flush_en_i || rd_en_i) ? '1 : (wr_en_i ? repl_oh_i : '0);
  assign tag_we   = flush_en_i | wr_en_i;
  // data RAMs stay out of a flush
  assign data_req = rd_en_i ? '1 : (wr_en_i ? repl_oh_i : '0);

  for (genvar i = 0; i < NUM_WAYS; i++) begin : gen_way
    logic [TAG_WIDTH:0] tag_valid;

    // valid bit on top, set on refill, cleared on flush
    sram_1rw #(
      .DATA_WIDTH ( TAG_WIDTH + 1 ),
      .NUM_WORDS  ( NUM_SETS      )
    ) i_tag_ram (
      .clk_i   ( clk_i                         ),
      .req_i   ( tag_req[i]                    ),
      .we_i    ( tag_we                        ),
      .addr_i  ( ram_idx                       ),
      .wdata_i ( {wr_en_i, addr_tag(addr_q_i)} ),
      .rdata_o ( tag_valid                     )
    );

    assign tags_o[i]  = tag_valid[TAG_WIDTH-1:0];
    assign valid_o[i] = tag_valid[TAG_WIDTH];

    sram_1rw #(
      .DATA_WIDTH ( LINE_WIDTH ),
      .NUM_WORDS  ( NUM_SETS   )
    ) i_data_ram (
      .clk_i   ( clk_i       ),
      .req_i   ( data_req[i] ),
      .we_i    ( wr_en_i     ),
      .addr_i  ( ram_idx     ),
      .wdata_i ( line_i      ),
      .rdata_o ( lines_o[i]  )
    );
  end

  // a refill never shares a cycle with a lookup or a flush
  a_wr_exclusive: assert property (
    @(posedge clk_i) disable iff (!rst_ni) wr_en_i |-> !(rd_en_i || flush_en_i))
    else $error("refill write collides with read or flush");

endmodule

// File: icache/icache_way_select.sv
/* tag compare, hit way encode, invalid way search, LFSR
   replacement and fetch word select */

`timescale 1ns/1ps

module icache_way_select (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic                                            lookup_i,
  input  logic                                            wr_en_i,
  input  icache_pkg::addr_t                               addr_q_i,
  input  icache_pkg::tag_t  [icache_pkg::NUM_WAYS-1:0]    tags_i,
  input  icache_pkg::way_oh_t                             valid_i,
  input  icache_pkg::line_t [icache_pkg::NUM_WAYS-1:0]    lines_i,
  input  icache_pkg::line_t                               rtrn_line_i,
  input  logic                                            from_mem_i,
  output logic                                            hit_o,
  output icache_pkg::way_oh_t                             repl_oh_o,
  output icache_pkg::word_t                               data_o
);

  import icache_pkg::*;

  way_oh_t               hit_oh;
  way_idx_t              hit_idx;
  way_idx_t              inv_way;
  way_idx_t              repl_way;
  logic                  all_valid;
  way_oh_t               repl_oh_q;
  logic [LFSR_WIDTH-1:0] lfsr_q;
  line_t                 sel_line;

  ////////////////////////////////////////////////////////////
  // tag compare and word select
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_WAYS; i++) begin : gen_cmp
    assign hit_oh[i] = valid_i[i] & (tags_i[i] == addr_tag(addr_q_i));
  end

  // RAM outputs only count in the cycle after a lookup read
  assign hit_o = lookup_i & (|hit_oh);

  // binary hit way, lowest set bit
  always_comb begin
    hit_idx = '0;
    for (int i = NUM_WAYS - 1; i >= 0; i--) begin
      if (hit_oh[i]) begin
        hit_idx = way_idx_t'(i);
      end
    end
  end

  // NC fills carry the word in every slot, so one offset works for both
  assign sel_line = from_mem_i ? rtrn_line_i : lines_i[hit_idx];
  assign data_o   = sel_line[addr_word(addr_q_i) * WORD_WIDTH +: WORD_WIDTH];

  ////////////////////////////////////////////////////////////
  // replacement
  ////////////////////////////////////////////////////////////

  // first invalid way, lowest index wins
  always_comb begin
    inv_way = '0;
    for (int i = NUM_WAYS - 1; i >= 0; i--) begin
      if (!valid_i[i]) begin
        inv_way = way_idx_t'(i);
      end
    end
  end

  assign all_valid = &valid_i;
  assign repl_way  = all_valid ? lfsr_q[$clog2(NUM_WAYS)-1:0] : inv_way;
  assign repl_oh_o = repl_oh_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      repl_oh_q <= '0;
      lfsr_q    <= LFSR_WIDTH'(1);
    end else begin
      // victim captured with the set that was just read
      if (lookup_i) begin
        repl_oh_q <= way_oh_t'(1) << repl_way;
      end
      // taps 8,6,5,4 for a maximal length sequence
      if (wr_en_i && all_valid) begin
        lfsr_q <= {lfsr_q[LFSR_WIDTH-2:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
      end
    end
  end

  // a line is never allocated twice in one set
  a_hit_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni) lookup_i |-> $onehot0(hit_oh))
    else $error("more than one way hit");

endmodule

// File: icache/icache_top.sv
/* 4-way set-associative instruction cache top level */

`timescale 1ns/1ps

module icache_top (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              en_i,
  input  logic              flush_i,
  // fetch port
  input  logic              req_i,
  input  icache_pkg::addr_t addr_i,
  output logic              ready_o,
  output logic              valid_o,
  output icache_pkg::word_t data_o,
  // performance counter
  output logic              miss_o,
  // next level memory
  output logic              mem_req_o,
  output icache_pkg::addr_t mem_addr_o,
  output logic              mem_nc_o,
  input  logic              mem_ack_i,
  input  logic              mem_rtrn_vld_i,
  input  icache_pkg::line_t mem_rtrn_data_i
);

  import icache_pkg::*;

  logic                     hit;
  logic                     from_mem;
  logic                     rd_en;
  logic                     wr_en;
  logic                     lookup;
  logic                     flush_en;
  index_t                   flush_idx;
  addr_t                    addr_d;
  addr_t                    addr_q;
  way_oh_t                  repl_oh;
  way_oh_t                  way_valid;
  tag_t  [NUM_WAYS-1:0]     tags;
  line_t [NUM_WAYS-1:0]     lines;

  icache_ctrl i_ctrl (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .en_i           ( en_i           ),
    .flush_i        ( flush_i        ),
    .req_i          ( req_i          ),
    .addr_i         ( addr_i         ),
    .ready_o        ( ready_o        ),
    .valid_o        ( valid_o        ),
    .miss_o         ( miss_o         ),
    .hit_i          ( hit            ),
    .from_mem_o     ( from_mem       ),
    .mem_req_o      ( mem_req_o      ),
    .mem_addr_o     ( mem_addr_o     ),
    .mem_nc_o       ( mem_nc_o       ),
    .mem_ack_i      ( mem_ack_i      ),
    .mem_rtrn_vld_i ( mem_rtrn_vld_i ),
    .rd_en_o        ( rd_en          ),
    .wr_en_o        ( wr_en          ),
    .lookup_o       ( lookup         ),
    .flush_en_o     ( flush_en       ),
    .flush_idx_o    ( flush_idx      ),
    .addr_d_o       ( addr_d         ),
    .addr_q_o       ( addr_q         )
  );

  icache_arrays i_arrays (
    .clk_i       ( clk_i           ),
    .rst_ni      ( rst_ni          ),
    .rd_en_i     ( rd_en           ),
    .wr_en_i     ( wr_en           ),
    .flush_en_i  ( flush_en        ),
    .flush_idx_i ( flush_idx       ),
    .addr_d_i    ( addr_d          ),
    .addr_q_i    ( addr_q          ),
    .repl_oh_i   ( repl_oh         ),
    .line_i      ( mem_rtrn_data_i ),
    .tags_o      ( tags            ),
    .valid_o     ( way_valid       ),
    .lines_o     ( lines           )
  );

  icache_way_select i_way_select (
    .clk_i       ( clk_i           ),
    .rst_ni      ( rst_ni          ),
    .lookup_i    ( lookup          ),
    .wr_en_i     ( wr_en           ),
    .addr_q_i    ( addr_q          ),
    .tags_i      ( tags            ),
    .valid_i     ( way_valid       ),
    .lines_i     ( lines           ),
    .rtrn_line_i ( mem_rtrn_data_i ),
    .from_mem_i  ( from_mem        ),
    .hit_o       ( hit             ),
    .repl_oh_o   ( repl_oh         ),
    .data_o      ( data_o          )
  );

endmodule

// File: test/tb_mem_model.sv
/* behavioral next level memory with random ack and return
   delays, request and non-cacheable counters */

`timescale 1ns/1ps

module tb_mem_model #(
  parameter logic [31:0] DATA_KEY = 32'h0
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              mem_req_i,
  input  icache_pkg::addr_t mem_addr_i,
  input  logic              mem_nc_i,
  output logic              mem_ack_o,
  output logic              mem_rtrn_vld_o,
  output icache_pkg::line_t mem_rtrn_data_o,
  output int                req_cnt_o,
  output int                nc_cnt_o,
  output logic              last_nc_o
);

  import icache_pkg::*;

  logic  busy;
  addr_t addr_q;
  logic  nc_q;
  int    ack_wait;
  int    rtrn_wait;

  // each word is its own byte address XOR the key
  // NC returns repeat the one requested word in every slot
  function automatic line_t line_for(input addr_t a, input logic nc);
    line_t l;
    addr_t wa;
    for (int k = 0; k < LINE_WIDTH / WORD_WIDTH; k++) begin
      wa = nc ? a : a + addr_t'(4 * k);
      l[k * WORD_WIDTH +: WORD_WIDTH] = wa ^ DATA_KEY;
    end
    return l;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy            <= 1'b0;
      addr_q          <= '0;
      nc_q            <= 1'b0;
      ack_wait        <= 0;
      rtrn_wait       <= 0;
      mem_ack_o       <= 1'b0;
      mem_rtrn_vld_o  <= 1'b0;
      mem_rtrn_data_o <= '0;
      req_cnt_o       <= 0;
      nc_cnt_o        <= 0;
      last_nc_o       <= 1'b0;
    end else begin
      mem_rtrn_vld_o <= 1'b0;
      if (mem_ack_o) begin
        // cache saw the ack on this edge, request taken
        mem_ack_o <= 1'b0;
        busy      <= 1'b1;
        addr_q    <= mem_addr_i;
        nc_q      <= mem_nc_i;
        rtrn_wait <= $urandom_range(5, 0);
        req_cnt_o <= req_cnt_o + 1;
        nc_cnt_o  <= nc_cnt_o + (mem_nc_i ? 1 : 0);
        last_nc_o <= mem_nc_i;
      end else if (busy) begin
        if (rtrn_wait == 0) begin
          mem_rtrn_vld_o  <= 1'b1;
          mem_rtrn_data_o <= line_for(addr_q, nc_q);
          busy            <= 1'b0;
        end else begin
          rtrn_wait <= rtrn_wait - 1;
        end
      end else if (mem_req_i) begin
        // request stays up until acked, so a late ack is safe
        if (ack_wait == 0) begin
          mem_ack_o <= 1'b1;
          ack_wait  <= $urandom_range(5, 0);
        end else begin
          ack_wait <= ack_wait - 1;
        end
      end
    end
  end

endmodule

// File: test/tb_icache.sv
/* icache testbench top with clock, reset, watchdog, directed tests
   and typed compare tasks */

`timescale 1ns/1ps

module tb_icache;

  import icache_pkg::*;

  ////////////////////////////////////////////////////////////
  // run parameters
  ////////////////////////////////////////////////////////////

  localparam int    CLK_PERIOD   = 100;
  localparam int    RESET_CYCLES = 16;
  localparam word_t DATA_KEY     = 32'h5a3c_96e1;
  // set shared by the replacement test
  localparam int    TEST_SET     = 5;
  localparam int    NUM_FETCHES  = 23;
  // a flush ahead of the fetch plus ack and return delays
  localparam int    FETCH_CYCLES = NUM_SETS + 16;
  // twice the worst case of all fetches
  localparam int    TIMEOUT_NS   =
    2 * (RESET_CYCLES + NUM_SETS + NUM_FETCHES * FETCH_CYCLES) * CLK_PERIOD;

  logic  clk;
  logic  rst_n;
  logic  en;
  logic  flush;
  logic  req;
  addr_t addr;
  logic  ready;
  logic  valid;
  word_t data;
  logic  miss;
  logic  mem_req;
  addr_t mem_addr;
  logic  mem_nc;
  logic  mem_ack;
  logic  mem_rtrn_vld;
  line_t mem_rtrn_data;
  int    req_cnt;
  int    nc_cnt;
  logic  last_nc;

  icache_top UUT (
    .clk_i           ( clk           ),
    .rst_ni          ( rst_n         ),
    .en_i            ( en            ),
    .flush_i         ( flush         ),
    .req_i           ( req           ),
    .addr_i          ( addr          ),
    .ready_o         ( ready         ),
    .valid_o         ( valid         ),
    .data_o          ( data          ),
    .miss_o          ( miss          ),
    .mem_req_o       ( mem_req       ),
    .mem_addr_o      ( mem_addr      ),
    .mem_nc_o        ( mem_nc        ),
    .mem_ack_i       ( mem_ack       ),
    .mem_rtrn_vld_i  ( mem_rtrn_vld  ),
    .mem_rtrn_data_i ( mem_rtrn_data )
  );

  tb_mem_model #(
    .DATA_KEY ( DATA_KEY )
  ) i_mem (
    .clk_i           ( clk           ),
    .rst_ni          ( rst_n         ),
    .mem_req_i       ( mem_req       ),
    .mem_addr_i      ( mem_addr      ),
    .mem_nc_i        ( mem_nc        ),
    .mem_ack_o       ( mem_ack       ),
    .mem_rtrn_vld_o  ( mem_rtrn_vld  ),
    .mem_rtrn_data_o ( mem_rtrn_data ),
    .req_cnt_o       ( req_cnt       ),
    .nc_cnt_o        ( nc_cnt        ),
    .last_nc_o       ( last_nc       )
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic end_with_failure();
    $display("Regression failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("** Error at %0d ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("** Error at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // fetch helpers
  ////////////////////////////////////////////////////////////

  // word aligned address XOR the key
  function automatic word_t expected_word(input addr_t a);
    return {a[ADDR_WIDTH-1:2], 2'b00} ^ DATA_KEY;
  endfunction

  // one request with outputs sampled on falling edges where they are settled
  task automatic fetch(input addr_t a, output word_t rdata, output int lat,
                       output int misses);
    lat    = 0;
    misses = 0;
    @(posedge clk);
    req  <= 1'b1;
    addr <= a;
    @(negedge clk);
    while (!ready) begin
      @(negedge clk);
    end
    // accepted on this rising edge
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    lat = 1;
    while (!valid) begin
      if (miss) begin
        misses++;
      end
      @(negedge clk);
      lat++;
    end
    rdata = data;
  endtask

  // new_reqs below zero leaves the request count open
  task automatic fetch_check(input addr_t a, input int new_reqs, input logic exp_nc);
    word_t got;
    int    lat;
    int    misses;
    int    reqs;
    int    ncs;
    int    reqs_before;
    int    nc_before;
    reqs_before = req_cnt;
    nc_before   = nc_cnt;
    fetch(a, got, lat, misses);
    reqs = req_cnt - reqs_before;
    ncs  = nc_cnt - nc_before;
    check_word("data_o", got, expected_word(a));
    if (new_reqs >= 0) begin
      check_count("memory requests", reqs, new_reqs);
    end
    if (reqs > 0) begin
      check_bit("mem_nc_o", last_nc, exp_nc);
    end
    check_count("non-cacheable requests", ncs, exp_nc ? reqs : 0);
    // each cacheable request is one miss
    check_count("miss_o pulses", misses, reqs - ncs);
    if (reqs == 0) begin
      check_count("hit latency", lat, 1);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic cold_fetch_refills();
    fetch_check(32'h0000_1234, 1, 1'b0);
  endtask

  // every word of the refilled line hits
  task automatic refilled_line_hits();
    for (int w = 0; w < 4; w++) begin
      fetch_check(32'h0000_1230 + addr_t'(4 * w), 0, 1'b0);
    end
  endtask

  task automatic nc_region_bypass();
    repeat (2) begin
      fetch_check(32'h8000_0104, 1, 1'b1);
    end
  endtask

  task automatic disabled_cache_bypass();
    @(posedge clk);
    en <= 1'b0;
    fetch_check(32'h0000_1238, 1, 1'b1);
    // enabling again flushes so the line is gone
    @(posedge clk);
    en <= 1'b1;
    fetch_check(32'h0000_1238, 1, 1'b0);
  endtask

  task automatic flush_forces_miss();
    fetch_check(32'h0000_123c, 0, 1'b0);
    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    fetch_check(32'h0000_123c, 1, 1'b0);
  endtask

  // six tags in one set with two shuffled fetches each
  task automatic same_set_replacement();
    addr_t lines [6];
    int    order [12];
    bit    seen  [6];
    int    j;
    int    tmp;
    addr_t a;
    for (int i = 0; i < 6; i++) begin
      lines[i] = (addr_t'(i + 1) << (OFFSET_WIDTH + INDEX_WIDTH)) |
                 (addr_t'(TEST_SET) << OFFSET_WIDTH);
      seen[i]  = 1'b0;
    end
    for (int i = 0; i < 12; i++) begin
      order[i] = i / 2;
    end
    for (int i = 11; i > 0; i--) begin
      j        = $urandom_range(i, 0);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < 12; i++) begin
      a = lines[order[i]] | addr_t'(4 * $urandom_range(3, 0));
      // a second fetch may have been evicted
      fetch_check(a, seen[order[i]] ? -1 : 1, 1'b0);
      seen[order[i]] = 1'b1;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(5522));
    clk   = 1'b0;
    rst_n = 1'b0;
    en    = 1'b0;
    flush = 1'b0;
    req   = 1'b0;
    addr  = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    en <= 1'b1;
    cold_fetch_refills();
    refilled_line_hits();
    nc_region_bypass();
    disabled_cache_bypass();
    flush_forces_miss();
    same_set_replacement();
    $display("Regression passed");
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog timeout, a fetch did not complete in time");
    end_with_failure();
  end

endmodule

// File: all.f
common/icache_pkg.sv
verilog/sram_1rw.sv
icache/icache_ctrl.sv
icache/icache_arrays.sv
icache/icache_way_select.sv
icache/icache_top.sv
test/tb_mem_model.sv
test/tb_icache.sv

// File: run.sh
#!/bin/sh
# build the icache testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_icache -f all.f || exit 1

out="$(./obj_dir/Vtb_icache 2>&1)"
echo "$out"

echo "$out" | grep -qx "Regression passed" && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }
